/* verilog.f */
+incdir+.
rtg_video_pkg.sv
rtg_ctrl_pkg.sv
rtg_fetch_timing.sv
rtg_pixel_decode.sv
video_mixer.sv
rtg_video_top.sv
rtg_video_assert.sv
tb_rtg_video.sv

/* run_sim.sh */
#!/bin/sh
# build the rtg video testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_rtg_video -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$log"; then
  exit 0
fi

echo "simulation did not report a pass, see $log"
exit 1

/* tb_rtg_video.sv */
`timescale 1ns/1ps

module tb_rtg_video;

  localparam int max_cycles = 20000; // tests run about 3000 cycles

  logic                     clk_114;
  logic                     rst_n;
  rtg_ctrl_pkg::rtg_mode_t  rtg_mode;
  logic                     hblank;
  logic                     vblank;
  rtg_video_pkg::sync_t     native_sync;
  rtg_video_pkg::rgb_t      native_rgb;
  rtg_video_pkg::sync_t     sync_pol;
  logic                     osd_window;
  logic                     osd_pixel;
  rtg_video_pkg::rtg_word_t rtg_dat;
  rtg_video_pkg::rgb_t      clut_rgb;
  logic                     rtg_pixel;
  rtg_video_pkg::color_t    clut_idx;
  rtg_video_pkg::vga_rgb_t  vga_rgb;
  rtg_video_pkg::sync_t     vga_sync;

  int errors = 0;
  int checks = 0;
  int test_err = 0; // errors before the current test
  int cycles = 0;

  rtg_video_top rtg_video_top_i (
    .clk_114     (clk_114),
    .rst_n       (rst_n),
    .rtg_mode    (rtg_mode),
    .hblank      (hblank),
    .vblank      (vblank),
    .native_sync (native_sync),
    .native_rgb  (native_rgb),
    .sync_pol    (sync_pol),
    .osd_window  (osd_window),
    .osd_pixel   (osd_pixel),
    .rtg_dat     (rtg_dat),
    .clut_rgb    (clut_rgb),
    .rtg_pixel   (rtg_pixel),
    .clut_idx    (clut_idx),
    .vga_rgb     (vga_rgb),
    .vga_sync    (vga_sync)
  );

  bind rtg_fetch_timing rtg_video_assert rtg_video_assert_i (
    .clk_114     (clk_114),
    .rst_n       (rst_n),
    .ena         (mode.ena),
    .pixel_width (mode.pixel_width),
    .vb_flag     (vb_flag),
    .rtg_pixel   (rtg_pixel)
  );

  initial begin
    clk_114 = 1'b0;
    forever #10 clk_114 = ~clk_114; // 50 MHz in sim
  end

  always @(posedge clk_114) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic expect_vga(input logic [5:0] r, input logic [5:0] g, input logic [5:0] b);
    check_value("vga_rgb.red", 32'(vga_rgb.red), 32'(r));
    check_value("vga_rgb.green", 32'(vga_rgb.green), 32'(g));
    check_value("vga_rgb.blue", 32'(vga_rgb.blue), 32'(b));
  endtask

  task automatic report_test(input string name);
    if (errors == test_err) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_err);
    end
    test_err = errors;
  endtask

  // n more edges, then sample mid cycle
  task automatic settle(input int n);
    repeat (n) @(posedge clk_114);
    @(negedge clk_114);
  endtask

  // mode changes under hblank so no strobe is cut short
  task automatic drive_mode(input logic ena, input logic clut,
                            input rtg_ctrl_pkg::pixel_width_t pw,
                            input rtg_ctrl_pkg::vb_line_t vbe);
    @(posedge clk_114);
    hblank <= 1'b1;
    @(posedge clk_114);
    rtg_mode.ena         <= ena;
    rtg_mode.clut        <= clut;
    rtg_mode.ext         <= 1'b0;
    rtg_mode.pixel_width <= pw;
    rtg_mode.vb_end      <= vbe;
    @(posedge clk_114);
    hblank <= 1'b0;
  endtask

  task automatic wait_strobe(input int limit, output int gap);
    int n;
    n = 0;
    do begin
      @(negedge clk_114);
      n++;
    end while (!rtg_pixel && n < limit);
    if (rtg_pixel) begin
      gap = n;
    end else begin
      gap = -1;
      errors++;
      $display("no fetch strobe within %0d cycles at %0t", limit, $time);
    end
  endtask

  task automatic hold_quiet(input int n, input logic quiet);
    repeat (n) begin
      @(negedge clk_114);
      if (quiet) begin
        check_value("rtg_pixel", 32'(rtg_pixel), 32'd0); // fetch held off
      end
    end
  endtask

  // one native line, low then high, so one rising edge
  task automatic hsync_line(input logic quiet);
    @(posedge clk_114);
    native_sync.hsync <= 1'b0;
    hold_quiet(4, quiet);
    @(posedge clk_114);
    native_sync.hsync <= 1'b1;
    hold_quiet(4, quiet);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic native_passthrough();
    logic [31:0] rnd;
    rtg_video_pkg::rgb_t  rgb;
    rtg_video_pkg::sync_t syn;
    rtg_video_pkg::sync_t pol;
    drive_mode(1'b0, 1'b0, 4'd0, 7'd0);
    repeat (20) begin
      rnd = $urandom;
      rgb = rnd[23:0];
      syn = rnd[25:24];
      pol = rnd[27:26];
      @(posedge clk_114);
      native_rgb  <= rgb;
      native_sync <= syn;
      sync_pol    <= pol;
      settle(2); // mixer then output register
      expect_vga(rgb.red[7:2], rgb.green[7:2], rgb.blue[7:2]);
      check_value("vga_sync", 32'(vga_sync), 32'(syn ^ pol));
    end
    report_test("native passthrough");
  endtask

  task automatic osd_overlay();
    logic [31:0] rnd;
    rtg_video_pkg::rgb_t rgb;
    logic [1:0] rg_code;
    logic [1:0] b_code;
    repeat (20) begin
      rnd = $urandom;
      rgb = rnd[23:0];
      rg_code = rnd[24] ? 2'b11 : 2'b00;
      b_code  = rnd[24] ? 2'b11 : 2'b10; // background tinted blue
      @(posedge clk_114);
      native_rgb <= rgb;
      osd_window <= 1'b1;
      osd_pixel  <= rnd[24];
      settle(2);
      expect_vga({rg_code, rgb.red[7:4]}, {rg_code, rgb.green[7:4]}, {b_code, rgb.blue[7:4]});
    end
    @(posedge clk_114);
    osd_window <= 1'b0;
    osd_pixel  <= 1'b0;
    report_test("osd overlay");
  endtask

  task automatic strobe_period();
    logic [31:0] rnd;
    rtg_ctrl_pkg::pixel_width_t pw;
    int gap;
    repeat (5) begin
      rnd = $urandom;
      pw  = rnd[3:0];
      drive_mode(1'b1, 1'b0, pw, 7'd0);
      @(posedge clk_114);
      hblank <= 1'b1;
      hold_quiet(12, 1'b1); // no fetch in hblank
      @(posedge clk_114);
      hblank <= 1'b0;
      wait_strobe(40, gap); // first strobe sets the phase
      repeat (6) begin
        wait_strobe(40, gap);
        if (gap > 0) begin
          check_value("rtg_pixel spacing", 32'(gap), 32'(pw) + 32'd1);
        end
      end
    end
    report_test("strobe period");
  endtask

  task automatic vblank_line_count();
    logic [31:0] rnd;
    rtg_ctrl_pkg::vb_line_t vbe;
    int gap;
    rnd = $urandom_range(8, 2);
    vbe = rnd[6:0];
    drive_mode(1'b1, 1'b0, 4'd1, vbe);
    @(posedge clk_114);
    native_sync <= 2'b11; // both syncs idle high
    vblank      <= 1'b1;
    @(posedge clk_114); // flag set from here
    hold_quiet(3, 1'b1);
    @(posedge clk_114);
    vblank <= 1'b0;
    repeat (int'(vbe) - 1) hsync_line(1'b1);
    repeat (2) hsync_line(1'b0); // last counted edge then one spare
    wait_strobe(40, gap);
    report_test("vblank line count");
  endtask

  task automatic hicolor_decode();
    logic [31:0] rnd;
    rtg_video_pkg::rtg_word_t word;
    drive_mode(1'b1, 1'b0, 4'd3, 7'd0);
    repeat (20) begin
      rnd  = $urandom;
      word = rnd[15:0];
      @(posedge clk_114);
      rtg_dat <= word;
      settle(3); // decode, mixer, output
      expect_vga({word[14:10], word[14]}, {word[9:5], word[9]}, {word[4:0], word[4]});
    end
    report_test("hi-colour decode");
  endtask

  task automatic clut_lookup();
    logic [31:0] rnd;
    rtg_ctrl_pkg::pixel_width_t pw;
    rtg_video_pkg::rtg_word_t word;
    rtg_video_pkg::rgb_t col;
    logic seen_hi;
    logic seen_lo;
    int gap;
    repeat (4) begin
      rnd = $urandom_range(15, 3); // room for both bytes in one period
      pw  = rnd[3:0];
      drive_mode(1'b1, 1'b1, pw, 7'd0);
      rnd  = $urandom;
      word = rnd[15:0];
      if (word[15:8] == word[7:0]) begin
        word[7:0] = ~word[7:0]; // bytes must differ
      end
      rnd = $urandom;
      col = rnd[23:0];
      @(posedge clk_114);
      rtg_dat  <= word;
      clut_rgb <= col;
      wait_strobe(40, gap);
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      repeat (int'(pw) + 1) begin
        @(negedge clk_114);
        if (clut_idx == word[15:8]) begin
          seen_hi = 1'b1;
        end else if (seen_hi && clut_idx == word[7:0]) begin
          seen_lo = 1'b1;
        end
      end
      checks++;
      if (!(seen_hi && seen_lo)) begin
        errors++;
        $display("clut_idx did not go from the high byte to the low byte in one fetch period");
      end
      expect_vga(col.red[7:2], col.green[7:2], col.blue[7:2]);
    end
    report_test("clut mode");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] seed;
    seed        = $urandom(86000); // one seed for the whole run
    rst_n       = 1'b0;
    rtg_mode    = '0;
    hblank      = 1'b0;
    vblank      = 1'b0;
    native_sync = 2'b11;
    native_rgb  = '0;
    sync_pol    = '0;
    osd_window  = 1'b0;
    osd_pixel   = 1'b0;
    rtg_dat     = '0;
    clut_rgb    = '0;
    repeat (3) @(posedge clk_114);
    rst_n <= 1'b1;
    native_passthrough();
    osd_overlay();
    strobe_period();
    vblank_line_count();
    hicolor_decode();
    clut_lookup();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* rtg_video_assert.sv */
`timescale 1ns/1ps

module rtg_video_assert (
  input logic                       clk_114,
  input logic                       rst_n,
  input logic                       ena,         // rtg on
  input rtg_ctrl_pkg::pixel_width_t pixel_width, // fetch period - 1
  input logic                       vb_flag,     // rtg vblank area
  input logic                       rtg_pixel    // fetch strobe
);

  ////////////////////////////////////////////////////////////
  // fetch strobe rules
  ////////////////////////////////////////////////////////////

  // no fifo reads with rtg off
  pixel_off: assert property (@(posedge clk_114) disable iff (!rst_n)
    !ena |-> !rtg_pixel)
    else $error("rtg_pixel high while rtg is off");

  // period of two or more clocks
  pixel_gap: assert property (@(posedge clk_114) disable iff (!rst_n)
    (rtg_pixel && pixel_width != '0) |=> !rtg_pixel)
    else $error("rtg_pixel high on two consecutive cycles");

  // ext may let only the first flagged clock through
  vblank_quiet: assert property (@(posedge clk_114) disable iff (!rst_n)
    (vb_flag && $past(vb_flag)) |-> !rtg_pixel)
    else $error("rtg_pixel high inside the rtg vblank area");

endmodule

/* rtg_video_top.sv */
`timescale 1ns/1ps

module rtg_video_top (
  input  logic                    clk_114,
  input  logic                    rst_n,
  input  rtg_ctrl_pkg::rtg_mode_t rtg_mode,    // static rtg mode
  input  logic                    hblank,
  input  logic                    vblank,
  input  rtg_video_pkg::sync_t    native_sync, // active low
  input  rtg_video_pkg::rgb_t     native_rgb,
  input  rtg_video_pkg::sync_t    sync_pol,
  input  logic                    osd_window,
  input  logic                    osd_pixel,
  input  rtg_video_pkg::rtg_word_t rtg_dat,    // fifo output
  input  rtg_video_pkg::rgb_t     clut_rgb,    // clut output
  output logic                    rtg_pixel,   // fifo read strobe
  output rtg_video_pkg::color_t   clut_idx,    // clut address
  output rtg_video_pkg::vga_rgb_t vga_rgb,
  output rtg_video_pkg::sync_t    vga_sync
);

  logic                clut_sel;     // byte phase
  logic                rtg_blank_d2; // blank aligned with rtg_rgb
  rtg_video_pkg::rgb_t rtg_rgb;      // decoded rtg colour

  ////////////////////////////////////////////////////////////
  // fetch timing
  ////////////////////////////////////////////////////////////

  rtg_fetch_timing rtg_fetch_timing_i (
    .clk_114      (clk_114),
    .rst_n        (rst_n),
    .mode         (rtg_mode),
    .hblank       (hblank),
    .vblank       (vblank),
    .hsync        (native_sync.hsync), // line clock for vblank count
    .rtg_pixel    (rtg_pixel),
    .clut_sel     (clut_sel),
    .rtg_blank_d2 (rtg_blank_d2)
  );

  ////////////////////////////////////////////////////////////
  // pixel decode
  ////////////////////////////////////////////////////////////

  rtg_pixel_decode rtg_pixel_decode_i (
    .clk_114   (clk_114),
    .rst_n     (rst_n),
    .clut_mode (rtg_mode.clut),
    .rtg_dat   (rtg_dat),
    .clut_sel  (clut_sel),
    .clut_rgb  (clut_rgb),
    .clut_idx  (clut_idx),
    .rtg_rgb   (rtg_rgb)
  );

  ////////////////////////////////////////////////////////////
  // mixer and output
  ////////////////////////////////////////////////////////////

  video_mixer video_mixer_i (
    .clk_114      (clk_114),
    .rst_n        (rst_n),
    .rtg_ena      (rtg_mode.ena),
    .rtg_blank_d2 (rtg_blank_d2),
    .rtg_rgb      (rtg_rgb),
    .native_rgb   (native_rgb),
    .native_sync  (native_sync),
    .sync_pol     (sync_pol),
    .osd_window   (osd_window),
    .osd_pixel    (osd_pixel),
    .vga_rgb      (vga_rgb),
    .vga_sync     (vga_sync)
  );

endmodule

/* video_mixer.sv */
`timescale 1ns/1ps
`include "rtg_video_cfg.svh"

module video_mixer (
  input  logic                    clk_114,
  input  logic                    rst_n,
  input  logic                    rtg_ena,      // rtg screen on
  input  logic                    rtg_blank_d2, // rtg blank, aligned
  input  rtg_video_pkg::rgb_t     rtg_rgb,      // decoded rtg colour
  input  rtg_video_pkg::rgb_t     native_rgb,   // chipset colour
  input  rtg_video_pkg::sync_t    native_sync,  // chipset syncs, active low
  input  rtg_video_pkg::sync_t    sync_pol,     // 1 inverts that sync
  input  logic                    osd_window,   // osd box area
  input  logic                    osd_pixel,    // osd foreground
  output rtg_video_pkg::vga_rgb_t vga_rgb,
  output rtg_video_pkg::sync_t    vga_sync
);

  rtg_video_pkg::rgb_t  mix_rgb;  // selected source
  rtg_video_pkg::rgb_t  osd_rgb;  // after overlay
  rtg_video_pkg::sync_t sync_q;   // aligned with mix_rgb
  logic [1:0]           osd_rg;   // code for red and green
  logic [1:0]           osd_b;    // code for blue

  // osd code on top, picture shifted down and dimmed
  function automatic rtg_video_pkg::color_t overlay(input rtg_video_pkg::color_t c,
                                                    input logic [1:0] code);
    overlay = {code, c[`COLOR_W-1:2]};
  endfunction

  // top bits only, the dac is narrower
  function automatic rtg_video_pkg::vga_color_t trunc(input rtg_video_pkg::color_t c);
    trunc = c[`COLOR_W-1 -: `OUT_W];
  endfunction

  ////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      mix_rgb <= '0;
      sync_q  <= '0;
    end else begin
      mix_rgb <= (rtg_ena && !rtg_blank_d2) ? rtg_rgb : native_rgb; // native in borders
      sync_q  <= native_sync;
    end
  end

  ////////////////////////////////////////////////////////////
  // osd overlay and output register
  ////////////////////////////////////////////////////////////

  assign osd_rg = osd_pixel ? `OSD_ON_RG : `OSD_OFF_RG;
  assign osd_b  = osd_pixel ? `OSD_ON_B : `OSD_OFF_B;

  assign osd_rgb.red   = osd_window ? overlay(mix_rgb.red, osd_rg) : mix_rgb.red;
  assign osd_rgb.green = osd_window ? overlay(mix_rgb.green, osd_rg) : mix_rgb.green;
  assign osd_rgb.blue  = osd_window ? overlay(mix_rgb.blue, osd_b) : mix_rgb.blue;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      vga_rgb  <= '0;
      vga_sync <= '0;
    end else begin
      vga_rgb.red   <= trunc(osd_rgb.red);
      vga_rgb.green <= trunc(osd_rgb.green);
      vga_rgb.blue  <= trunc(osd_rgb.blue);
      vga_sync      <= sync_q ^ sync_pol; // monitor polarity
    end
  end

endmodule

/* rtg_pixel_decode.sv */
`timescale 1ns/1ps
`include "rtg_video_cfg.svh"

module rtg_pixel_decode (
  input  logic                     clk_114,
  input  logic                     rst_n,
  input  logic                     clut_mode, // indexed, else rgb555
  input  rtg_video_pkg::rtg_word_t rtg_dat,   // fifo output word
  input  logic                     clut_sel,  // byte phase from timing
  input  rtg_video_pkg::rgb_t      clut_rgb,  // clut value for clut_idx
  output rtg_video_pkg::color_t    clut_idx,  // to the clut memory
  output rtg_video_pkg::rgb_t      rtg_rgb    // decoded colour
);

  logic                clut_sel_d; // matches clut read latency
  rtg_video_pkg::rgb_t hi_rgb;     // rgb555 expanded

  // 5 bit field to 8 bits, low bits repeat the top of the field
  function automatic rtg_video_pkg::color_t expand5(input logic [4:0] field);
    expand5 = {field, field[4:2]};
  endfunction

  ////////////////////////////////////////////////////////////
  // index select and hi-colour expand
  ////////////////////////////////////////////////////////////

  assign clut_idx = clut_sel_d ? rtg_dat[`COLOR_W-1:0]            // second pixel
                               : rtg_dat[`WORD_W-1 -: `COLOR_W];  // first pixel

  assign hi_rgb.red   = expand5(rtg_dat[14:10]);
  assign hi_rgb.green = expand5(rtg_dat[9:5]);
  assign hi_rgb.blue  = expand5(rtg_dat[4:0]); // bit 15 unused

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      clut_sel_d <= 1'b0;
      rtg_rgb    <= '0;
    end else begin
      clut_sel_d <= clut_sel;
      if (clut_mode) begin
        rtg_rgb <= clut_rgb; // palette lookup
      end else begin
        rtg_rgb <= hi_rgb;   // direct colour
      end
    end
  end

endmodule

/* rtg_fetch_timing.sv */
`timescale 1ns/1ps

module rtg_fetch_timing (
  input  logic                   clk_114,
  input  logic                   rst_n,
  input  rtg_ctrl_pkg::rtg_mode_t mode,         // static rtg mode
  input  logic                   hblank,       // chipset hblank
  input  logic                   vblank,       // chipset vblank
  input  logic                   hsync,        // native hsync, active low
  output logic                   rtg_pixel,    // fetch strobe to the fifo
  output logic                   clut_sel,     // second clut byte phase
  output logic                   rtg_blank_d2  // blank, two clocks late
);

  rtg_ctrl_pkg::pixel_width_t pix_ctr;   // clocks since last fetch
  rtg_ctrl_pkg::pixel_width_t half_width; // clut byte switch point
  rtg_ctrl_pkg::vb_line_t     vb_ctr;    // lines since vblank
  logic                       vb_flag;   // rtg vblank area
  logic                       hsync_d;   // edge detect
  logic                       hsync_rise;
  logic                       rtg_blank;
  logic                       rtg_blank_d;

  ////////////////////////////////////////////////////////////
  // blank and fetch strobe
  ////////////////////////////////////////////////////////////

  assign rtg_blank  = vb_flag | hblank;
  assign half_width = mode.pixel_width >> 1;

  // fetch on counter match, ext lets one more fetch past blank start
  assign rtg_pixel = mode.ena &&
                     (!rtg_blank || (mode.ext && !rtg_blank_d)) &&
                     (pix_ctr == mode.pixel_width);

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      pix_ctr      <= '0;
      clut_sel     <= 1'b0;
      rtg_blank_d  <= 1'b0;
      rtg_blank_d2 <= 1'b0;
    end else begin
      rtg_blank_d  <= rtg_blank;   // for ext check
      rtg_blank_d2 <= rtg_blank_d; // lines up with decoded colour
      if (pix_ctr == half_width) begin
        clut_sel <= 1'b1; // second index halfway through the fetch
      end
      if (rtg_blank || rtg_pixel) begin
        pix_ctr  <= '0;   // restart period
        clut_sel <= 1'b0; // back to the high byte
      end else begin
        pix_ctr <= pix_ctr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // vblank line counter
  ////////////////////////////////////////////////////////////

  // counts native lines after chipset vblank ends
  assign hsync_rise = hsync & ~hsync_d;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      hsync_d <= 1'b0;
      vb_flag <= 1'b0;
      vb_ctr  <= '0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin
        vb_flag <= 1'b1; // hold off fetch
        vb_ctr  <= '0;
      end else if (vb_ctr == mode.vb_end) begin
        vb_flag <= 1'b0; // enough lines, release
      end else if (hsync_rise) begin
        vb_ctr <= vb_ctr + 1'b1;
      end
    end
  end

endmodule

/* rtg_ctrl_pkg.sv */
`include "rtg_video_cfg.svh"

package rtg_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // rtg control fields
  ////////////////////////////////////////////////////////////

  typedef logic [`PIXW_W-1:0] pixel_width_t; // clocks per fetch - 1
  typedef logic [`VBEND_W-1:0] vb_line_t;    // vblank height in lines

  // static mode set by the control logic
  typedef struct packed {
    logic         ena;         // rtg screen on
    logic         clut;        // 8 bit indexed, else hi-colour
    logic         ext;         // active area one clock longer
    pixel_width_t pixel_width; // fetch period - 1
    vb_line_t     vb_end;      // lines counted before fetch resumes
  } rtg_mode_t;

endpackage

/* rtg_video_pkg.sv */
`include "rtg_video_cfg.svh"

package rtg_video_pkg;

  ////////////////////////////////////////////////////////////
  // colour channels
  ////////////////////////////////////////////////////////////

  typedef logic [`COLOR_W-1:0] color_t;    // 8 bit channel
  typedef logic [`OUT_W-1:0] vga_color_t;  // truncated for the dac
  typedef logic [`WORD_W-1:0] rtg_word_t;  // rgb555 or two clut indices

  // full depth pixel
  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_t;

  // pixel as it leaves the chip
  typedef struct packed {
    vga_color_t red;
    vga_color_t green;
    vga_color_t blue;
  } vga_rgb_t;

  ////////////////////////////////////////////////////////////
  // sync
  ////////////////////////////////////////////////////////////

  // levels, native syncs are active low
  typedef struct packed {
    logic hsync;
    logic vsync;
  } sync_t;

endpackage

/* rtg_video_cfg.svh */
`ifndef RTG_VIDEO_CFG_SVH
`define RTG_VIDEO_CFG_SVH

////////////////////////////////////////////////////////////
// video format widths
////////////////////////////////////////////////////////////

`define COLOR_W 8  // internal colour channel
`define OUT_W   6  // vga dac channel
`define WORD_W  16 // one stream word from the fifo
`define PIXW_W  4  // clocks per fetch, minus one
`define VBEND_W 7  // lines in the rtg vblank area

////////////////////////////////////////////////////////////
// osd colour codes, top two bits of each channel
////////////////////////////////////////////////////////////

`define OSD_ON_RG  2'b11 // lit pixel, red and green
`define OSD_ON_B   2'b11 // lit pixel, blue
`define OSD_OFF_RG 2'b00 // window background, red and green
`define OSD_OFF_B  2'b10 // background has a blue tint

`endif
